/* sources.f */
src/tl_pkg.sv
src/top_pkg.sv
src/tl_if.sv
src/xbar_main.sv
src/tl_sram.sv
src/gpio.sv
src/rv_timer.sv
src/top_mini.sv
tests/tb_top.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_top -f sources.f -o tb_top_sim \
  && ./obj_dir/tb_top_sim > sim.log 2>&1 \
  || echo "build or simulation ended with an error status"

cat sim.log 2>/dev/null

grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tests/tb_top.sv */
////////////////////////////////////////
// directed testbench for top_mini, runs
// bus, GPIO, timer and back-pressure tests
////////////////////////////////////////
`timescale 1ns/100ps

module tb_top;
  import tl_pkg::*;
  import top_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int SAMPLE_DLY   = 1;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_WAIT     = 20;
  localparam int RAM_TESTS    = 16;
  localparam int TIMER_POLL   = 200;
  localparam int HOLD_CYCLES  = 6;
  // cycle budget of each test for the watchdog
  localparam int RAM_CYCLES   = RAM_TESTS * 3 * 3;
  localparam int ERR_CYCLES   = 40;
  localparam int GPIO_CYCLES  = 80;
  localparam int TIMER_CYCLES = TIMER_POLL + 40;
  localparam int BP_CYCLES    = 30;
  localparam int MARGIN       = 4;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + RAM_CYCLES + ERR_CYCLES + GPIO_CYCLES +
                                 TIMER_CYCLES + BP_CYCLES) * CLK_PERIOD * MARGIN;

  logic             clk;
  logic             rst_n;
  logic             tl_a_valid;
  logic             tl_a_write;
  logic [TL_AW-1:0] tl_a_addr;
  logic [TL_DW-1:0] tl_a_data;
  logic [TL_MW-1:0] tl_a_mask;
  logic             tl_a_ready;
  logic             tl_d_valid;
  logic [TL_DW-1:0] tl_d_data;
  logic             tl_d_error;
  logic             tl_d_ready;
  logic [31:0]      gpio_in;
  logic [31:0]      gpio_out;
  logic [31:0]      gpio_en;
  logic             intr_gpio;
  logic             intr_timer;

  int          seed = 32'h4625;
  int          error_count = 0;
  int unsigned cycle_cnt = 0;
  logic [31:0] ram_model [RAM_WORDS];

  top_mini u_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .tl_a_valid_i (tl_a_valid),
    .tl_a_write_i (tl_a_write),
    .tl_a_addr_i  (tl_a_addr),
    .tl_a_data_i  (tl_a_data),
    .tl_a_mask_i  (tl_a_mask),
    .tl_a_ready_o (tl_a_ready),
    .tl_d_valid_o (tl_d_valid),
    .tl_d_data_o  (tl_d_data),
    .tl_d_error_o (tl_d_error),
    .tl_d_ready_i (tl_d_ready),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_en_o    (gpio_en),
    .intr_gpio_o  (intr_gpio),
    .intr_timer_o (intr_timer)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic stop_with_failure();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic abort_run(input string reason);
    error_count++;
    $display("[ERROR] %s", reason);
    stop_with_failure();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    error_count++;
    $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    stop_with_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else report_mismatch(name, exp, act);
  endtask

  // byte lanes of new_word replace those of old_word where mask is set
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  mask);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] ram_addr(input logic [9:0] idx);
    return ADDR_RAM + {20'd0, idx, 2'b00};
  endfunction

  function automatic logic [31:0] gpio_reg(input logic [WINDOW_AW-1:0] off);
    return ADDR_GPIO + 32'(off);
  endfunction

  function automatic logic [31:0] timer_reg(input logic [WINDOW_AW-1:0] off);
    return ADDR_TIMER + 32'(off);
  endfunction

  // one request with its response one cycle after acceptance
  task automatic bus_access(input string name, input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] mask,
                            output logic [31:0] rdata, output logic err);
    int wait_cycles;
    wait_cycles = 0;
    @(negedge clk);
    tl_a_valid = 1'b1;
    tl_a_write = write;
    tl_a_addr  = addr;
    tl_a_data  = wdata;
    tl_a_mask  = mask;
    #(SAMPLE_DLY);
    while (!tl_a_ready) begin
      wait_cycles++;
      assert (wait_cycles < MAX_WAIT)
        else abort_run($sformatf("%s: request to 0x%08h never accepted", name, addr));
      @(negedge clk);
      #(SAMPLE_DLY);
    end
    // accepted on the rising edge before this one
    @(negedge clk);
    tl_a_valid  = 1'b0;
    #(SAMPLE_DLY);
    wait_cycles = 1;
    while (!tl_d_valid && wait_cycles < MAX_WAIT) begin
      @(negedge clk);
      #(SAMPLE_DLY);
      wait_cycles++;
    end
    assert (tl_d_valid)
      else abort_run($sformatf("%s: no response for address 0x%08h", name, addr));
    assert (wait_cycles == 1) else report_mismatch({name, " latency"}, 32'd1, wait_cycles);
    rdata = tl_d_data;
    err   = tl_d_error;
  endtask

  task automatic bus_write(input string name, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] mask, output logic [31:0] rdata, output logic err);
    bus_access(name, 1'b1, addr, wdata, mask, rdata, err);
  endtask

  task automatic bus_read(input string name, input logic [31:0] addr,
                          output logic [31:0] rdata, output logic err);
    bus_access(name, 1'b0, addr, 32'd0, 4'hF, rdata, err);
  endtask

  task automatic ram_read_write();
    logic [9:0]  idx [RAM_TESTS];
    logic [31:0] rnd;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        err;
    // full words first so that every touched byte is known
    for (int i = 0; i < RAM_TESTS; i++) begin
      rnd    = $random(seed);
      idx[i] = rnd[9:0];
      wdata  = $random(seed);
      bus_write("ram_rw", ram_addr(idx[i]), wdata, 4'hF, rdata, err);
      ram_model[idx[i]] = wdata;
      check_value("ram_rw write error", 32'd0, 32'(err));
      check_value("ram_rw write data", 32'd0, rdata);
    end
    for (int i = 0; i < RAM_TESTS; i++) begin
      rnd   = $random(seed);
      wdata = $random(seed);
      bus_write("ram_rw", ram_addr(idx[i]), wdata, rnd[3:0], rdata, err);
      ram_model[idx[i]] = merge_bytes(ram_model[idx[i]], wdata, rnd[3:0]);
      check_value("ram_rw masked write error", 32'd0, 32'(err));
    end
    for (int i = 0; i < RAM_TESTS; i++) begin
      bus_read("ram_rw", ram_addr(idx[i]), rdata, err);
      check_value("ram_rw read data", ram_model[idx[i]], rdata);
      check_value("ram_rw read error", 32'd0, 32'(err));
    end
  endtask

  task automatic address_errors();
    logic [31:0] ram_end;
    logic [31:0] rdata;
    logic        err;
    ram_end = ADDR_RAM + 32'(RAM_WORDS) * 32'd4;
    bus_write("addr_err", ram_addr(10'd0), 32'h1357_9BDF, 4'hF, rdata, err);
    check_value("addr_err ram write", 32'd0, 32'(err));
    bus_read("addr_err", 32'h2000_0000, rdata, err);
    check_value("addr_err unmapped read error", 32'd1, 32'(err));
    check_value("addr_err unmapped read data", 32'd0, rdata);
    // hole between the GPIO and timer windows
    bus_write("addr_err", 32'h4004_0000, 32'hFFFF_FFFF, 4'hF, rdata, err);
    check_value("addr_err unmapped write error", 32'd1, 32'(err));
    check_value("addr_err unmapped write data", 32'd0, rdata);
    bus_read("addr_err", ram_end, rdata, err);
    check_value("addr_err ram range read error", 32'd1, 32'(err));
    check_value("addr_err ram range read data", 32'd0, rdata);
    // would alias word 0 if the range check failed
    bus_write("addr_err", ram_end, 32'hDEAD_BEEF, 4'hF, rdata, err);
    check_value("addr_err ram range write error", 32'd1, 32'(err));
    bus_read("addr_err", ram_addr(10'd0), rdata, err);
    check_value("addr_err ram read after errors", 32'h1357_9BDF, rdata);
    check_value("addr_err ram read error", 32'd0, 32'(err));
  endtask

  task automatic gpio_out_in();
    logic [31:0] rdata;
    logic        err;
    bus_write("gpio_io", gpio_reg(GPIO_DATA_OUT), 32'hA5A5_3C3C, 4'hF, rdata, err);
    bus_write("gpio_io", gpio_reg(GPIO_DIR), 32'h1234_5678, 4'b0011, rdata, err);
    check_value("gpio_io gpio_o", 32'hA5A5_3C3C, gpio_out);
    check_value("gpio_io gpio_en_o", merge_bytes(32'd0, 32'h1234_5678, 4'b0011), gpio_en);
    @(negedge clk);
    gpio_in = 32'h8001_F00E;
    repeat (4) @(negedge clk);
    bus_read("gpio_io", gpio_reg(GPIO_DATA_IN), rdata, err);
    check_value("gpio_io data_in", 32'h8001_F00E, rdata);
    // offset not defined by the block
    bus_read("gpio_io", gpio_reg(12'h020), rdata, err);
    check_value("gpio_io undefined offset", 32'd0, rdata);
    check_value("gpio_io undefined offset error", 32'd0, 32'(err));
  endtask

  task automatic gpio_interrupt();
    logic [31:0] enabled;
    logic [31:0] raised;
    logic [31:0] rdata;
    logic        err;
    enabled = 32'h0000_00F0;
    raised  = 32'h0000_0330;
    @(negedge clk);
    gpio_in = 32'd0;
    repeat (4) @(negedge clk);
    // drop state left by earlier input edges
    bus_write("gpio_intr", gpio_reg(GPIO_INTR_STATE), 32'hFFFF_FFFF, 4'hF, rdata, err);
    bus_write("gpio_intr", gpio_reg(GPIO_INTR_ENABLE), enabled, 4'hF, rdata, err);
    bus_read("gpio_intr", gpio_reg(GPIO_INTR_STATE), rdata, err);
    check_value("gpio_intr state before", 32'd0, rdata);
    check_value("gpio_intr irq before", 32'd0, 32'(intr_gpio));
    @(negedge clk);
    gpio_in = raised;
    repeat (4) @(negedge clk);
    bus_read("gpio_intr", gpio_reg(GPIO_INTR_STATE), rdata, err);
    check_value("gpio_intr state", raised, rdata);
    check_value("gpio_intr irq", 32'(|(raised & enabled)), 32'(intr_gpio));
    // pins 6 and 7 are enabled but saw no edge
    bus_write("gpio_intr", gpio_reg(GPIO_INTR_ENABLE), enabled & ~raised, 4'hF, rdata, err);
    check_value("gpio_intr irq masked", 32'd0, 32'(intr_gpio));
    bus_write("gpio_intr", gpio_reg(GPIO_INTR_ENABLE), enabled, 4'hF, rdata, err);
    bus_write("gpio_intr", gpio_reg(GPIO_INTR_STATE), raised, 4'hF, rdata, err);
    bus_read("gpio_intr", gpio_reg(GPIO_INTR_STATE), rdata, err);
    check_value("gpio_intr state cleared", 32'd0, rdata);
    check_value("gpio_intr irq cleared", 32'd0, 32'(intr_gpio));
  endtask

  task automatic timer_interrupt();
    int unsigned start;
    logic        irq_seen;
    logic [31:0] rdata;
    logic        err;
    bus_write("timer", timer_reg(TIMER_PRESCALE), 32'd3, 4'hF, rdata, err);
    bus_write("timer", timer_reg(TIMER_MTIMECMP), 32'd20, 4'hF, rdata, err);
    bus_write("timer", timer_reg(TIMER_MTIME), 32'd0, 4'hF, rdata, err);
    bus_write("timer", timer_reg(TIMER_INTR_STATE), 32'd1, 4'hF, rdata, err);
    bus_read("timer", timer_reg(TIMER_PRESCALE), rdata, err);
    check_value("timer prescale", 32'd3, rdata);
    check_value("timer irq before enable", 32'd0, 32'(intr_timer));
    bus_write("timer", timer_reg(TIMER_CTRL), 32'd1, 4'hF, rdata, err);
    start    = cycle_cnt;
    irq_seen = 1'b0;
    while (!irq_seen && (cycle_cnt - start) < TIMER_POLL) begin
      // interrupt sampled ahead of the read since mtime only grows
      irq_seen = intr_timer;
      bus_read("timer", timer_reg(TIMER_MTIME), rdata, err);
      assert (!irq_seen || rdata >= 32'd20)
        else abort_run($sformatf("timer: interrupt high while mtime read %0d", rdata));
    end
    assert (irq_seen)
      else abort_run($sformatf("timer: interrupt did not rise within %0d cycles", TIMER_POLL));
    bus_write("timer", timer_reg(TIMER_MTIMECMP), 32'hFFFF_FFFF, 4'hF, rdata, err);
    bus_write("timer", timer_reg(TIMER_INTR_STATE), 32'd1, 4'hF, rdata, err);
    check_value("timer irq cleared", 32'd0, 32'(intr_timer));
    bus_read("timer", timer_reg(TIMER_INTR_STATE), rdata, err);
    check_value("timer state cleared", 32'd0, rdata);
    bus_write("timer", timer_reg(TIMER_CTRL), 32'd0, 4'hF, rdata, err);
  endtask

  task automatic back_pressure();
    logic [31:0] held;
    logic [31:0] rdata;
    logic        err;
    held = 32'h0BAD_CAFE;
    bus_write("backpressure", ram_addr(10'd3), held, 4'hF, rdata, err);
    @(negedge clk);
    tl_d_ready = 1'b0;
    tl_a_valid = 1'b1;
    tl_a_write = 1'b0;
    tl_a_addr  = ram_addr(10'd3);
    tl_a_mask  = 4'hF;
    #(SAMPLE_DLY);
    check_value("backpressure idle a_ready", 32'd1, 32'(tl_a_ready));
    // read taken at the next rising edge and a write queued behind it
    @(negedge clk);
    tl_a_write = 1'b1;
    tl_a_addr  = ram_addr(10'd4);
    tl_a_data  = 32'h600D_F00D;
    #(SAMPLE_DLY);
    check_value("backpressure d_valid", 32'd1, 32'(tl_d_valid));
    check_value("backpressure read data", held, tl_d_data);
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      #(SAMPLE_DLY);
      check_value("backpressure d_valid held", 32'd1, 32'(tl_d_valid));
      check_value("backpressure d_data held", held, tl_d_data);
      check_value("backpressure a_ready low", 32'd0, 32'(tl_a_ready));
    end
    @(negedge clk);
    tl_d_ready = 1'b1;
    @(negedge clk);
    #(SAMPLE_DLY);
    check_value("backpressure released d_valid", 32'd0, 32'(tl_d_valid));
    check_value("backpressure released a_ready", 32'd1, 32'(tl_a_ready));
    @(negedge clk);
    tl_a_valid = 1'b0;
    #(SAMPLE_DLY);
    check_value("backpressure write response", 32'd1, 32'(tl_d_valid));
    check_value("backpressure write error", 32'd0, 32'(tl_d_error));
    bus_read("backpressure", ram_addr(10'd4), rdata, err);
    check_value("backpressure queued write", 32'h600D_F00D, rdata);
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run($sformatf("watchdog: run did not finish within %0d ns", WATCHDOG_NS));
  end

  initial begin
    rst_n      = 1'b0;
    tl_a_valid = 1'b0;
    tl_a_write = 1'b0;
    tl_a_addr  = '0;
    tl_a_data  = '0;
    tl_a_mask  = '0;
    tl_d_ready = 1'b1;
    gpio_in    = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #(SAMPLE_DLY);
    check_value("reset d_valid", 32'd0, 32'(tl_d_valid));
    check_value("reset a_ready", 32'd1, 32'(tl_a_ready));
    check_value("reset gpio_o", 32'd0, gpio_out);
    check_value("reset gpio_en_o", 32'd0, gpio_en);
    check_value("reset intr_gpio", 32'd0, 32'(intr_gpio));
    check_value("reset intr_timer", 32'd0, 32'(intr_timer));
    ram_read_write();
    address_errors();
    gpio_out_in();
    gpio_interrupt();
    timer_interrupt();
    back_pressure();
    if (error_count == 0) begin
      $display("No errors");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule

/* src/top_mini.sv */
////////////////////////////////////////
// peripheral subsystem top level, one bus
// host port in, pads and interrupts out
////////////////////////////////////////
`timescale 1ns/100ps

module top_mini (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // bus host request
  input  logic                     tl_a_valid_i,
  input  logic                     tl_a_write_i,
  input  logic [tl_pkg::TL_AW-1:0] tl_a_addr_i,
  input  logic [tl_pkg::TL_DW-1:0] tl_a_data_i,
  input  logic [tl_pkg::TL_MW-1:0] tl_a_mask_i,
  output logic                     tl_a_ready_o,
  // bus host response
  output logic                     tl_d_valid_o,
  output logic [tl_pkg::TL_DW-1:0] tl_d_data_o,
  output logic                     tl_d_error_o,
  input  logic                     tl_d_ready_i,
  // gpio pads
  input  logic [31:0]              gpio_i,
  output logic [31:0]              gpio_o,
  output logic [31:0]              gpio_en_o,
  // interrupts, no PLIC in this subsystem
  output logic                     intr_gpio_o,
  output logic                     intr_timer_o
);
  import tl_pkg::*;

  tl_if tl_ram ();
  tl_if tl_gpio ();
  tl_if tl_timer ();

  xbar_main u_xbar_main (
    .clk_i,
    .rst_n_i,
    .a_valid_i (tl_a_valid_i),
    // write flag maps onto OP_PUT
    .a_op_i    (tl_op_e'(tl_a_write_i)),
    .a_addr_i  (tl_a_addr_i),
    .a_data_i  (tl_a_data_i),
    .a_mask_i  (tl_a_mask_i),
    .a_ready_o (tl_a_ready_o),
    .d_valid_o (tl_d_valid_o),
    .d_data_o  (tl_d_data_o),
    .d_error_o (tl_d_error_o),
    .d_ready_i (tl_d_ready_i),
    .tl_ram    (tl_ram),
    .tl_gpio   (tl_gpio),
    .tl_timer  (tl_timer)
  );

  // main RAM
  tl_sram u_ram (
    .clk_i,
    .rst_n_i,
    .tl      (tl_ram)
  );

  gpio u_gpio (
    .clk_i,
    .rst_n_i,
    .tl          (tl_gpio),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o),
    .intr_gpio_o (intr_gpio_o)
  );

  rv_timer u_timer (
    .clk_i,
    .rst_n_i,
    .tl           (tl_timer),
    .intr_timer_o (intr_timer_o)
  );

endmodule

/* src/rv_timer.sv */
////////////////////////////////////////
// machine timer, prescaled mtime with a
// compare register and expiry interrupt
////////////////////////////////////////
`timescale 1ns/100ps

module rv_timer (
  input  logic clk_i,
  input  logic rst_n_i,
  tl_if.device tl,
  output logic intr_timer_o
);
  import tl_pkg::*;
  import top_pkg::*;

  logic [WINDOW_AW-1:0] reg_off;
  logic                 accept;
  logic                 wr;
  logic [TL_DW-1:0]     rdata;
  logic [TL_DW-1:0]     prescale_wr;
  logic                 tick_wrap;
  logic                 expired;
  logic                 intr_clr;
  logic                 enable_q;
  logic [TIMER_PSW-1:0] prescale_q;
  logic [TIMER_PSW-1:0] tick_q;
  logic [31:0]          mtime_q;
  logic [31:0]          mtimecmp_q;
  logic                 intr_state_q;
  logic                 d_valid_q;
  logic [TL_DW-1:0]     d_data_q;

  assign reg_off = tl.a_addr[WINDOW_AW-1:0];
  assign accept  = tl.a_valid & ~d_valid_q;
  assign wr      = accept & (tl.a_op == OP_PUT);

  assign tl.a_ready = ~d_valid_q;
  assign tl.d_valid = d_valid_q;
  assign tl.d_data  = d_data_q;
  assign tl.d_error = 1'b0;

  assign prescale_wr = masked_wr(TL_DW'(prescale_q), tl.a_data, tl.a_mask);
  // mtime steps once every prescale+1 cycles
  assign tick_wrap   = tick_q >= prescale_q;
  assign expired     = mtime_q >= mtimecmp_q;
  assign intr_clr    = wr & (reg_off == TIMER_INTR_STATE) & tl.a_mask[0] & tl.a_data[0];

  always_comb begin
    case (reg_off)
      TIMER_CTRL:       rdata = {31'b0, enable_q};
      TIMER_PRESCALE:   rdata = TL_DW'(prescale_q);
      TIMER_MTIME:      rdata = mtime_q;
      TIMER_MTIMECMP:   rdata = mtimecmp_q;
      TIMER_INTR_STATE: rdata = {31'b0, intr_state_q};
      default:          rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q     <= 1'b0;
      prescale_q   <= '0;
      tick_q       <= '0;
      mtime_q      <= '0;
      mtimecmp_q   <= '1;
      intr_state_q <= 1'b0;
    end else begin
      if (wr && reg_off == TIMER_CTRL && tl.a_mask[0]) begin
        enable_q <= tl.a_data[0];
      end
      if (wr && reg_off == TIMER_PRESCALE) begin
        prescale_q <= prescale_wr[TIMER_PSW-1:0];
      end
      if (wr && reg_off == TIMER_MTIMECMP) begin
        mtimecmp_q <= masked_wr(mtimecmp_q, tl.a_data, tl.a_mask);
      end
      // prescaler runs only while enabled
      if (!enable_q || tick_wrap) begin
        tick_q <= '0;
      end else begin
        tick_q <= tick_q + 1'b1;
      end
      // a software write to mtime takes priority over the tick
      if (wr && reg_off == TIMER_MTIME) begin
        mtime_q <= masked_wr(mtime_q, tl.a_data, tl.a_mask);
      end else if (enable_q && tick_wrap) begin
        mtime_q <= mtime_q + 32'd1;
      end
      intr_state_q <= (intr_state_q & ~intr_clr) | expired;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      d_data_q <= (tl.a_op == OP_GET) ? rdata : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      d_valid_q <= 1'b0;
    end else if (accept) begin
      d_valid_q <= 1'b1;
    end else if (tl.d_ready) begin
      d_valid_q <= 1'b0;
    end
  end

  assign intr_timer_o = intr_state_q;

endmodule

/* src/gpio.sv */
////////////////////////////////////////
// 32-bit GPIO with synchronized inputs,
// output enables and rising-edge interrupts
////////////////////////////////////////
`timescale 1ns/100ps

module gpio (
  input  logic        clk_i,
  input  logic        rst_n_i,
  tl_if.device        tl,
  input  logic [31:0] gpio_i,
  output logic [31:0] gpio_o,
  output logic [31:0] gpio_en_o,
  output logic        intr_gpio_o
);
  import tl_pkg::*;
  import top_pkg::*;

  logic [WINDOW_AW-1:0] reg_off;
  logic                 accept;
  logic                 wr;
  logic [31:0]          rdata;
  logic [31:0]          intr_clr;
  logic [31:0]          edge_rise;
  logic [31:0]          sync_q;
  logic [31:0]          data_in_q;
  logic [31:0]          data_in_prev_q;
  logic [31:0]          data_out_q;
  logic [31:0]          dir_q;
  logic [31:0]          intr_en_q;
  logic [31:0]          intr_state_q;
  logic                 d_valid_q;
  logic [TL_DW-1:0]     d_data_q;

  assign reg_off = tl.a_addr[WINDOW_AW-1:0];
  assign accept  = tl.a_valid & ~d_valid_q;
  assign wr      = accept & (tl.a_op == OP_PUT);

  assign tl.a_ready = ~d_valid_q;
  assign tl.d_valid = d_valid_q;
  assign tl.d_data  = d_data_q;
  assign tl.d_error = 1'b0;

  // rising edge after the two-flop synchronizer
  assign edge_rise = data_in_q & ~data_in_prev_q;
  // write one to clear
  assign intr_clr  = (wr && reg_off == GPIO_INTR_STATE) ?
                     masked_wr('0, tl.a_data, tl.a_mask) : '0;

  always_comb begin
    case (reg_off)
      GPIO_DATA_IN:     rdata = data_in_q;
      GPIO_DATA_OUT:    rdata = data_out_q;
      GPIO_DIR:         rdata = dir_q;
      GPIO_INTR_ENABLE: rdata = intr_en_q;
      GPIO_INTR_STATE:  rdata = intr_state_q;
      default:          rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q         <= '0;
      data_in_q      <= '0;
      data_in_prev_q <= '0;
      data_out_q     <= '0;
      dir_q          <= '0;
      intr_en_q      <= '0;
      intr_state_q   <= '0;
    end else begin
      sync_q         <= gpio_i;
      data_in_q      <= sync_q;
      data_in_prev_q <= data_in_q;
      // a new edge wins over a clear in the same cycle
      intr_state_q   <= (intr_state_q & ~intr_clr) | edge_rise;
      if (wr && reg_off == GPIO_DATA_OUT) begin
        data_out_q <= masked_wr(data_out_q, tl.a_data, tl.a_mask);
      end
      if (wr && reg_off == GPIO_DIR) begin
        dir_q <= masked_wr(dir_q, tl.a_data, tl.a_mask);
      end
      if (wr && reg_off == GPIO_INTR_ENABLE) begin
        intr_en_q <= masked_wr(intr_en_q, tl.a_data, tl.a_mask);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      d_data_q <= (tl.a_op == OP_GET) ? rdata : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      d_valid_q <= 1'b0;
    end else if (accept) begin
      d_valid_q <= 1'b1;
    end else if (tl.d_ready) begin
      d_valid_q <= 1'b0;
    end
  end

  assign gpio_o      = data_out_q;
  assign gpio_en_o   = dir_q;
  assign intr_gpio_o = |(intr_state_q & intr_en_q);

endmodule

/* src/tl_sram.sv */
////////////////////////////////////////
// bus adapter and byte-masked RAM with
// the response one cycle after a request
////////////////////////////////////////
`timescale 1ns/100ps

module tl_sram (
  input logic  clk_i,
  input logic  rst_n_i,
  tl_if.device tl
);
  import tl_pkg::*;
  import top_pkg::*;

  logic [TL_DW-1:0]      mem [RAM_WORDS];
  logic [RAM_WIN_AW-3:0] win_idx;
  logic [RAM_IW-1:0]     word_idx;
  logic                  out_of_range;
  logic                  accept;
  logic                  d_valid_q;
  logic [TL_DW-1:0]      d_data_q;
  logic                  d_error_q;

  // word index inside the RAM window
  assign win_idx      = tl.a_addr[RAM_WIN_AW-1:2];
  assign word_idx     = win_idx[RAM_IW-1:0];
  assign out_of_range = (win_idx >= RAM_WORDS);

  assign accept     = tl.a_valid & ~d_valid_q;
  assign tl.a_ready = ~d_valid_q;
  assign tl.d_valid = d_valid_q;
  assign tl.d_data  = d_data_q;
  assign tl.d_error = d_error_q;

  // byte lane writes
  always_ff @(posedge clk_i) begin
    if (accept && tl.a_op == OP_PUT && !out_of_range) begin
      for (int b = 0; b < TL_MW; b++) begin
        if (tl.a_mask[b]) begin
          mem[word_idx][8*b +: 8] <= tl.a_data[8*b +: 8];
        end
      end
    end
  end

  // response payload, zero data on writes and errors
  always_ff @(posedge clk_i) begin
    if (accept) begin
      d_data_q  <= (tl.a_op == OP_GET && !out_of_range) ? mem[word_idx] : '0;
      d_error_q <= out_of_range;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      d_valid_q <= 1'b0;
    end else if (accept) begin
      d_valid_q <= 1'b1;
    end else if (tl.d_ready) begin
      d_valid_q <= 1'b0;
    end
  end

endmodule

/* src/xbar_main.sv */
////////////////////////////////////////
// main crossbar, one host to RAM, GPIO
// and timer, errors on unmapped space
////////////////////////////////////////
`timescale 1ns/100ps

module xbar_main (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // host side
  input  logic                     a_valid_i,
  input  tl_pkg::tl_op_e           a_op_i,
  input  logic [tl_pkg::TL_AW-1:0] a_addr_i,
  input  logic [tl_pkg::TL_DW-1:0] a_data_i,
  input  logic [tl_pkg::TL_MW-1:0] a_mask_i,
  output logic                     a_ready_o,
  output logic                     d_valid_o,
  output logic [tl_pkg::TL_DW-1:0] d_data_o,
  output logic                     d_error_o,
  input  logic                     d_ready_i,
  // device side
  tl_if.host                       tl_ram,
  tl_if.host                       tl_gpio,
  tl_if.host                       tl_timer
);
  import tl_pkg::*;
  import top_pkg::*;

  logic [1:0] sel;
  logic       sel_ready;
  logic       accept;
  logic       busy_q;
  logic [1:0] owner_q;

  // window decode on the upper address bits
  always_comb begin
    if (a_addr_i[TL_AW-1:RAM_WIN_AW] == ADDR_RAM[TL_AW-1:RAM_WIN_AW]) begin
      sel = TGT_RAM;
    end else if (a_addr_i[TL_AW-1:WINDOW_AW] == ADDR_GPIO[TL_AW-1:WINDOW_AW]) begin
      sel = TGT_GPIO;
    end else if (a_addr_i[TL_AW-1:WINDOW_AW] == ADDR_TIMER[TL_AW-1:WINDOW_AW]) begin
      sel = TGT_TIMER;
    end else begin
      sel = TGT_ERR;
    end
  end

  always_comb begin
    case (sel)
      TGT_RAM:   sel_ready = tl_ram.a_ready;
      TGT_GPIO:  sel_ready = tl_gpio.a_ready;
      TGT_TIMER: sel_ready = tl_timer.a_ready;
      default:   sel_ready = 1'b1;
    endcase
  end

  // one request in flight at a time
  assign a_ready_o = ~busy_q & sel_ready;
  assign accept    = a_valid_i & a_ready_o;

  // request fields fan out, valid only to the selected device
  assign tl_ram.a_valid   = a_valid_i & ~busy_q & (sel == TGT_RAM);
  assign tl_ram.a_op      = a_op_i;
  assign tl_ram.a_addr    = a_addr_i;
  assign tl_ram.a_data    = a_data_i;
  assign tl_ram.a_mask    = a_mask_i;
  assign tl_ram.d_ready   = d_ready_i & busy_q & (owner_q == TGT_RAM);

  assign tl_gpio.a_valid  = a_valid_i & ~busy_q & (sel == TGT_GPIO);
  assign tl_gpio.a_op     = a_op_i;
  assign tl_gpio.a_addr   = a_addr_i;
  assign tl_gpio.a_data   = a_data_i;
  assign tl_gpio.a_mask   = a_mask_i;
  assign tl_gpio.d_ready  = d_ready_i & busy_q & (owner_q == TGT_GPIO);

  assign tl_timer.a_valid = a_valid_i & ~busy_q & (sel == TGT_TIMER);
  assign tl_timer.a_op    = a_op_i;
  assign tl_timer.a_addr  = a_addr_i;
  assign tl_timer.a_data  = a_data_i;
  assign tl_timer.a_mask  = a_mask_i;
  assign tl_timer.d_ready = d_ready_i & busy_q & (owner_q == TGT_TIMER);

  // response from the owner of the pending request
  always_comb begin
    d_valid_o = 1'b0;
    d_data_o  = '0;
    d_error_o = 1'b0;
    if (busy_q) begin
      case (owner_q)
        TGT_RAM: begin
          d_valid_o = tl_ram.d_valid;
          d_data_o  = tl_ram.d_data;
          d_error_o = tl_ram.d_error;
        end
        TGT_GPIO: begin
          d_valid_o = tl_gpio.d_valid;
          d_data_o  = tl_gpio.d_data;
          d_error_o = tl_gpio.d_error;
        end
        TGT_TIMER: begin
          d_valid_o = tl_timer.d_valid;
          d_data_o  = tl_timer.d_data;
          d_error_o = tl_timer.d_error;
        end
        default: begin
          // unmapped, answered here one cycle after acceptance
          d_valid_o = 1'b1;
          d_error_o = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      owner_q <= TGT_ERR;
    end else if (accept) begin
      busy_q  <= 1'b1;
      owner_q <= sel;
    end else if (d_valid_o && d_ready_i) begin
      busy_q  <= 1'b0;
    end
  end

endmodule

/* src/tl_if.sv */
////////////////////////////////////////
// one request/response bus channel; the
// crossbar holds host, peripherals device
////////////////////////////////////////
`timescale 1ns/100ps

interface tl_if;
  import tl_pkg::*;

  // request channel
  logic             a_valid;
  logic             a_ready;
  tl_op_e           a_op;
  logic [TL_AW-1:0] a_addr;
  logic [TL_DW-1:0] a_data;
  logic [TL_MW-1:0] a_mask;

  // response channel
  logic             d_valid;
  logic             d_ready;
  logic [TL_DW-1:0] d_data;
  logic             d_error;

  modport host (
    output a_valid, a_op, a_addr, a_data, a_mask, d_ready,
    input  a_ready, d_valid, d_data, d_error
  );

  modport device (
    input  a_valid, a_op, a_addr, a_data, a_mask, d_ready,
    output a_ready, d_valid, d_data, d_error
  );

endinterface

/* src/top_pkg.sv */
////////////////////////////////////////
// chip address map, RAM size and the
// register offsets of GPIO and timer
////////////////////////////////////////
package top_pkg;

  // window sizes in address bits
  localparam int WINDOW_AW  = 12;
  // RAM window is wider than the array, upper indices answer with an error
  localparam int RAM_WIN_AW = 14;

  // base addresses
  localparam logic [tl_pkg::TL_AW-1:0] ADDR_RAM   = 32'h1000_0000;
  localparam logic [tl_pkg::TL_AW-1:0] ADDR_GPIO  = 32'h4000_0000;
  localparam logic [tl_pkg::TL_AW-1:0] ADDR_TIMER = 32'h4008_0000;

  // main RAM
  localparam int RAM_WORDS = 1024;
  localparam int RAM_IW    = $clog2(RAM_WORDS);

  // crossbar targets, TGT_ERR is the crossbar itself
  localparam logic [1:0] TGT_RAM   = 2'd0;
  localparam logic [1:0] TGT_GPIO  = 2'd1;
  localparam logic [1:0] TGT_TIMER = 2'd2;
  localparam logic [1:0] TGT_ERR   = 2'd3;

  // gpio register offsets
  localparam logic [WINDOW_AW-1:0] GPIO_DATA_IN     = 12'h000;
  localparam logic [WINDOW_AW-1:0] GPIO_DATA_OUT    = 12'h004;
  localparam logic [WINDOW_AW-1:0] GPIO_DIR         = 12'h008;
  localparam logic [WINDOW_AW-1:0] GPIO_INTR_ENABLE = 12'h00C;
  localparam logic [WINDOW_AW-1:0] GPIO_INTR_STATE  = 12'h010;

  // timer register offsets and prescaler width
  localparam logic [WINDOW_AW-1:0] TIMER_CTRL       = 12'h000;
  localparam logic [WINDOW_AW-1:0] TIMER_PRESCALE   = 12'h004;
  localparam logic [WINDOW_AW-1:0] TIMER_MTIME      = 12'h008;
  localparam logic [WINDOW_AW-1:0] TIMER_MTIMECMP   = 12'h00C;
  localparam logic [WINDOW_AW-1:0] TIMER_INTR_STATE = 12'h010;
  localparam int TIMER_PSW = 12;

endpackage

/* src/tl_pkg.sv */
////////////////////////////////////////
// bus protocol widths, opcodes and the
// byte-mask merge used by register blocks
////////////////////////////////////////
package tl_pkg;

  // address, data and byte mask widths
  localparam int TL_AW = 32;
  localparam int TL_DW = 32;
  localparam int TL_MW = TL_DW / 8;

  // request opcode, one bit on the wire
  typedef enum logic {
    OP_GET = 1'b0,
    OP_PUT = 1'b1
  } tl_op_e;

  // merge new_word into old_word on the bytes selected by mask
  function automatic logic [TL_DW-1:0] masked_wr(
    input logic [TL_DW-1:0] old_word,
    input logic [TL_DW-1:0] new_word,
    input logic [TL_MW-1:0] mask
  );
    logic [TL_DW-1:0] bit_mask;
    for (int b = 0; b < TL_MW; b++) begin
      bit_mask[8*b +: 8] = {8{mask[b]}};
    end
    return (old_word & ~bit_mask) | (new_word & bit_mask);
  endfunction

endpackage
